// ==== lu_cplx_pkg.sv ====
`default_nettype none

package lu_cplx_pkg;

  // signed Q7.8 parts
  localparam int data_w = 16;
  localparam int frac_w = 8;

  typedef struct packed {
    logic signed [data_w-1:0] re;
    logic signed [data_w-1:0] im;
  } cplx_t;

endpackage

`default_nettype wire

// ==== lu_mem_pkg.sv ====
`default_nettype none

package lu_mem_pkg;

  localparam int mat_n  = 4;
  localparam int addr_w = 2;

  // element 0 sits in the low bits
  typedef lu_cplx_pkg::cplx_t [mat_n-1:0] row_t;

  localparam logic [addr_w-1:0] last_row = addr_w'(mat_n - 1);
  localparam logic [addr_w-1:0] last_piv = addr_w'(mat_n - 2);

  // requester ids at the arbiter
  localparam logic req_host   = 1'b0;
  localparam logic req_engine = 1'b1;

endpackage

`default_nettype wire

// ==== row_bus_if.sv ====
`default_nettype none

interface row_bus_if;

  logic                          req;
  logic                          we;
  logic [lu_mem_pkg::addr_w-1:0] addr;
  lu_mem_pkg::row_t              wdata;
  logic                          gnt;    // same cycle as accept
  logic                          rvalid; // one cycle after read grant
  lu_mem_pkg::row_t              rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

// ==== row_mem.sv ====
`default_nettype none

module row_mem (
  input  logic                          clk_i,
  input  logic                          we_i,
  input  logic                          re_i,
  input  logic [lu_mem_pkg::addr_w-1:0] addr_i,
  input  lu_mem_pkg::row_t              wdata_i,
  output lu_mem_pkg::row_t              rdata_o
);

  lu_mem_pkg::row_t mem_q [lu_mem_pkg::mat_n];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    if (re_i) begin
      rdata_o <= mem_q[addr_i]; // one cycle read latency
    end
  end

endmodule

`default_nettype wire

// ==== row_mem_arbiter.sv ====
`default_nettype none

module row_mem_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  row_bus_if.arbiter                    host_bus,
  row_bus_if.arbiter                    eng_bus,
  output logic                          mem_we_o,
  output logic                          mem_re_o,
  output logic [lu_mem_pkg::addr_w-1:0] mem_addr_o,
  output lu_mem_pkg::row_t              mem_wdata_o,
  input  lu_mem_pkg::row_t              mem_rdata_i
);

  logic last_q;     // last granted requester
  logic rd_pend_q;
  logic rd_owner_q;
  logic gnt_host;
  logic gnt_eng;
  logic sel;

  always_comb begin
    // engine wins a tie only if host went last
    gnt_eng  = eng_bus.req & (~host_bus.req | (last_q == lu_mem_pkg::req_host));
    gnt_host = host_bus.req & ~gnt_eng;
    sel      = gnt_eng ? lu_mem_pkg::req_engine : lu_mem_pkg::req_host;

    host_bus.gnt = gnt_host;
    eng_bus.gnt  = gnt_eng;

    mem_we_o    = (gnt_host & host_bus.we) | (gnt_eng & eng_bus.we);
    mem_re_o    = (gnt_host & ~host_bus.we) | (gnt_eng & ~eng_bus.we);
    mem_addr_o  = (sel == lu_mem_pkg::req_engine) ? eng_bus.addr : host_bus.addr;
    mem_wdata_o = (sel == lu_mem_pkg::req_engine) ? eng_bus.wdata : host_bus.wdata;

    // data goes to both, only the owner sees rvalid
    host_bus.rvalid = rd_pend_q & (rd_owner_q == lu_mem_pkg::req_host);
    eng_bus.rvalid  = rd_pend_q & (rd_owner_q == lu_mem_pkg::req_engine);
    host_bus.rdata  = mem_rdata_i;
    eng_bus.rdata   = mem_rdata_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      last_q     <= lu_mem_pkg::req_engine; // host first after reset
      rd_pend_q  <= 1'b0;
      rd_owner_q <= lu_mem_pkg::req_host;
    end else begin
      if (gnt_host | gnt_eng) begin
        last_q <= sel;
      end
      rd_pend_q <= mem_re_o;
      if (mem_re_o) begin
        rd_owner_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cplx_recip.sv ====
`default_nettype none

module cplx_recip (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  lu_cplx_pkg::cplx_t pivot_i,
  output logic               busy_o,
  output logic               done_o,
  output lu_cplx_pkg::cplx_t recip_o,
  output logic               singular_o
);

  typedef enum logic [1:0] {st_idle, st_div, st_sat} state_t;

  state_t                              state_q;
  logic [4:0]                          cnt_q;
  logic [lu_cplx_pkg::data_w-1:0]      abs_re_d, abs_im_d, abs_im_q;
  logic [2*lu_cplx_pkg::data_w-1:0]    mag_d, mag_q;
  logic [2*lu_cplx_pkg::data_w:0]      rem_q, rem_in, rem_sh;
  logic [2*lu_cplx_pkg::data_w-1:0]    quo_q;  // re bits high, im bits low
  logic                                q_bit;
  logic                                neg_re_q, neg_im_q, ovf_re_q, ovf_im_q, zero_q;

  function automatic logic [lu_cplx_pkg::data_w-1:0] sat_part(
    input logic [lu_cplx_pkg::data_w-1:0] q,
    input logic                           ovf,
    input logic                           neg
  );
    logic [lu_cplx_pkg::data_w-1:0] lim;
    lim = neg ? {1'b1, {(lu_cplx_pkg::data_w-1){1'b0}}}
              : {1'b0, {(lu_cplx_pkg::data_w-1){1'b1}}};
    if (ovf || q > lim) begin
      sat_part = lim;
    end else if (neg) begin
      sat_part = -q;
    end else begin
      sat_part = q;
    end
  endfunction

  always_comb begin
    abs_re_d = pivot_i.re[lu_cplx_pkg::data_w-1] ? -pivot_i.re : pivot_i.re;
    abs_im_d = pivot_i.im[lu_cplx_pkg::data_w-1] ? -pivot_i.im : pivot_i.im;
    mag_d    = {{lu_cplx_pkg::data_w{1'b0}}, abs_re_d} * {{lu_cplx_pkg::data_w{1'b0}}, abs_re_d}
             + {{lu_cplx_pkg::data_w{1'b0}}, abs_im_d} * {{lu_cplx_pkg::data_w{1'b0}}, abs_im_d};
    // second quotient restarts from |im|
    rem_in = (cnt_q == 5'(lu_cplx_pkg::data_w)) ? {{(lu_cplx_pkg::data_w+1){1'b0}}, abs_im_q}
                                                : rem_q;
    rem_sh = {rem_in[2*lu_cplx_pkg::data_w-1:0], 1'b0};
    q_bit  = rem_sh >= {1'b0, mag_q};
    busy_o = state_q != st_idle;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= st_idle;
      cnt_q      <= '0;
      done_o     <= 1'b0;
      singular_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        st_idle: begin
          if (start_i) begin
            cnt_q   <= '0;
            state_q <= st_div;
          end
        end
        st_div: begin
          cnt_q <= cnt_q + 5'd1;
          if (cnt_q == 5'd31) begin
            state_q <= st_sat;
          end
        end
        st_sat: begin
          done_o     <= 1'b1;
          singular_o <= zero_q;
          state_q    <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && start_i) begin
      abs_im_q <= abs_im_d;
      mag_q    <= mag_d;
      rem_q    <= {{(lu_cplx_pkg::data_w+1){1'b0}}, abs_re_d};
      neg_re_q <= pivot_i.re[lu_cplx_pkg::data_w-1];
      neg_im_q <= ~pivot_i.im[lu_cplx_pkg::data_w-1] && (pivot_i.im != '0); // -im
      // quotient would need a 17th bit
      ovf_re_q <= {{lu_cplx_pkg::data_w{1'b0}}, abs_re_d} >= mag_d;
      ovf_im_q <= {{lu_cplx_pkg::data_w{1'b0}}, abs_im_d} >= mag_d;
      zero_q   <= mag_d == '0;
    end
    if (state_q == st_div) begin
      rem_q <= q_bit ? rem_sh - {1'b0, mag_q} : rem_sh;
      quo_q <= {quo_q[2*lu_cplx_pkg::data_w-2:0], q_bit};
    end
    if (state_q == st_sat) begin
      if (zero_q) begin
        recip_o <= '0;
      end else begin
        recip_o.re <= sat_part(quo_q[2*lu_cplx_pkg::data_w-1:lu_cplx_pkg::data_w],
                               ovf_re_q, neg_re_q);
        recip_o.im <= sat_part(quo_q[lu_cplx_pkg::data_w-1:0], ovf_im_q, neg_im_q);
      end
    end
  end

endmodule

`default_nettype wire

// ==== cplx_mul.sv ====
`default_nettype none

module cplx_mul (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               in_valid_i,
  input  lu_cplx_pkg::cplx_t a_i,
  input  lu_cplx_pkg::cplx_t b_i,
  output logic               out_valid_o,
  output lu_cplx_pkg::cplx_t prod_o
);

  logic signed [2*lu_cplx_pkg::data_w-1:0] rr_q, ii_q, ri_q, ir_q;
  logic signed [2*lu_cplx_pkg::data_w:0]   re_sum, im_sum;
  logic [1:0]                              vld_q;

  always_comb begin
    re_sum = rr_q - ii_q;
    im_sum = ri_q + ir_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[0], in_valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    // stage one, partial products
    rr_q <= a_i.re * b_i.re;
    ii_q <= a_i.im * b_i.im;
    ri_q <= a_i.re * b_i.im;
    ir_q <= a_i.im * b_i.re;
    // stage two, floor shift then wrap
    prod_o.re <= re_sum[lu_cplx_pkg::frac_w +: lu_cplx_pkg::data_w];
    prod_o.im <= im_sum[lu_cplx_pkg::frac_w +: lu_cplx_pkg::data_w];
  end

  assign out_valid_o = vld_q[1];

endmodule

`default_nettype wire

// ==== lu_engine.sv ====
`default_nettype none

module lu_engine (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  row_bus_if.requester mem,
  output logic         busy_o,
  output logic         done_o,
  output logic         singular_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_piv_rd,
    st_piv_wait,
    st_recip,
    st_row_rd,
    st_row_wait,
    st_row_wr,
    st_finish
  } state_t;

  state_t                        state_q;
  logic [lu_mem_pkg::addr_w-1:0] k_q;      // pivot index
  logic [lu_mem_pkg::addr_w-1:0] i_q;      // row being updated
  logic                          sing_q;
  lu_mem_pkg::row_t              piv_row_q, row_q, wr_row_q, new_row, vprod;
  lu_cplx_pkg::cplx_t            recip_q, recip_res, l_q, smul_prod;
  logic                          piv_rvalid, row_rvalid;
  logic                          recip_done, recip_sing;
  logic                          smul_valid;
  logic [lu_mem_pkg::mat_n-1:0]  vmul_valid;
  logic                          vmul_done;

  assign piv_rvalid = (state_q == st_piv_wait) & mem.rvalid;
  assign row_rvalid = (state_q == st_row_wait) & mem.rvalid;
  assign vmul_done  = (state_q == st_row_wait) & (&vmul_valid);

  cplx_recip u_recip (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (piv_rvalid),
    .pivot_i    (mem.rdata[k_q]),
    .busy_o     (),
    .done_o     (recip_done),
    .recip_o    (recip_res),
    .singular_o (recip_sing)
  );

  // l = a[i][k] * 1/pivot
  cplx_mul u_smul (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (row_rvalid),
    .a_i         (mem.rdata[k_q]),
    .b_i         (recip_q),
    .out_valid_o (smul_valid),
    .prod_o      (smul_prod)
  );

  for (genvar j = 0; j < lu_mem_pkg::mat_n; j++) begin : g_lane
    cplx_mul u_vmul (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .in_valid_i  (smul_valid),
      .a_i         (smul_prod),
      .b_i         (piv_row_q[j]),
      .out_valid_o (vmul_valid[j]),
      .prod_o      (vprod[j])
    );
  end

  always_comb begin
    for (int j = 0; j < lu_mem_pkg::mat_n; j++) begin
      new_row[j] = row_q[j]; // left of k kept
      if (j == int'(k_q)) begin
        new_row[j] = l_q;
      end else if (j > int'(k_q)) begin
        new_row[j].re = row_q[j].re - vprod[j].re;
        new_row[j].im = row_q[j].im - vprod[j].im;
      end
    end
  end

  always_comb begin
    mem.req   = (state_q == st_piv_rd) || (state_q == st_row_rd) || (state_q == st_row_wr);
    mem.we    = state_q == st_row_wr;
    mem.addr  = (state_q == st_piv_rd) ? k_q : i_q;
    mem.wdata = wr_row_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      k_q     <= '0;
      i_q     <= '0;
      sing_q  <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start_i) begin
            k_q     <= '0;
            sing_q  <= 1'b0;
            state_q <= st_piv_rd;
          end
        end
        st_piv_rd:   if (mem.gnt) state_q <= st_piv_wait;
        st_piv_wait: if (mem.rvalid) state_q <= st_recip;
        st_recip: begin
          if (recip_done) begin
            sing_q  <= sing_q | recip_sing;
            i_q     <= k_q + 1'b1;
            state_q <= st_row_rd;
          end
        end
        st_row_rd:   if (mem.gnt) state_q <= st_row_wait;
        st_row_wait: if (vmul_done) state_q <= st_row_wr;
        st_row_wr: begin
          // write held until granted
          if (mem.gnt) begin
            if (i_q != lu_mem_pkg::last_row) begin
              i_q     <= i_q + 1'b1;
              state_q <= st_row_rd;
            end else if (k_q != lu_mem_pkg::last_piv) begin
              k_q     <= k_q + 1'b1;
              state_q <= st_piv_rd;
            end else begin
              state_q <= st_finish;
            end
          end
        end
        st_finish: state_q <= st_idle;
        default:   state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (piv_rvalid) begin
      piv_row_q <= mem.rdata;
    end
    if (recip_done) begin
      recip_q <= recip_res;
    end
    if (row_rvalid) begin
      row_q <= mem.rdata;
    end
    if (smul_valid) begin
      l_q <= smul_prod;
    end
    if (vmul_done) begin
      wr_row_q <= new_row;
    end
  end

  assign busy_o     = state_q != st_idle;
  assign done_o     = state_q == st_finish;
  assign singular_o = sing_q;

endmodule

`default_nettype wire

// ==== lu_top.sv ====
`default_nettype none

module lu_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic                          host_req_i,
  input  logic                          host_we_i,
  input  logic [lu_mem_pkg::addr_w-1:0] host_addr_i,
  input  lu_mem_pkg::row_t              host_wdata_i,
  output logic                          host_gnt_o,
  output logic                          host_rvalid_o,
  output lu_mem_pkg::row_t              host_rdata_o,
  output logic                          busy_o,
  output logic                          done_o,
  output logic                          singular_o
);

  logic                          mem_we;
  logic                          mem_re;
  logic [lu_mem_pkg::addr_w-1:0] mem_addr;
  lu_mem_pkg::row_t              mem_wdata;
  lu_mem_pkg::row_t              mem_rdata;

  row_bus_if host_bus ();
  row_bus_if eng_bus ();

  assign host_bus.req   = host_req_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_gnt_o     = host_bus.gnt;
  assign host_rvalid_o  = host_bus.rvalid;
  assign host_rdata_o   = host_bus.rdata;

  row_mem_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .host_bus    (host_bus),
    .eng_bus     (eng_bus),
    .mem_we_o    (mem_we),
    .mem_re_o    (mem_re),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  row_mem u_mem (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .re_i    (mem_re),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  lu_engine u_engine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .mem        (eng_bus),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .singular_o (singular_o)
  );

endmodule

`default_nettype wire

// ==== lu_ref_model.svh ====
`ifndef LU_REF_MODEL_SVH
`define LU_REF_MODEL_SVH

typedef lu_mem_pkg::row_t [lu_mem_pkg::mat_n-1:0] mat_t;

function automatic logic signed [15:0] sat16(input longint v);
  logic signed [15:0] r;
  if (v > 32767) begin
    r = 16'sh7fff;
  end else if (v < -32768) begin
    r = 16'sh8000;
  end else begin
    r = v[15:0];
  end
  return r;
endfunction

// full product, floor shift, wrap
function automatic lu_cplx_pkg::cplx_t mul_q8(input lu_cplx_pkg::cplx_t a,
                                              input lu_cplx_pkg::cplx_t b);
  longint re;
  longint im;
  lu_cplx_pkg::cplx_t r;
  re   = longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
  im   = longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
  re   = re >>> lu_cplx_pkg::frac_w;
  im   = im >>> lu_cplx_pkg::frac_w;
  r.re = re[15:0];
  r.im = im[15:0];
  return r;
endfunction

function automatic lu_cplx_pkg::cplx_t sub_wrap(input lu_cplx_pkg::cplx_t a,
                                                input lu_cplx_pkg::cplx_t b);
  lu_cplx_pkg::cplx_t r;
  r.re = a.re - b.re;
  r.im = a.im - b.im;
  return r;
endfunction

function automatic lu_cplx_pkg::cplx_t recip_q8(input lu_cplx_pkg::cplx_t p);
  longint mag;
  lu_cplx_pkg::cplx_t r;
  mag = longint'(p.re) * longint'(p.re) + longint'(p.im) * longint'(p.im);
  r   = '0;
  if (mag != 0) begin
    r.re = sat16((longint'(p.re) * 65536) / mag); // division truncates toward zero
    r.im = sat16((-longint'(p.im) * 65536) / mag);
  end
  return r;
endfunction

// in place, L below the diagonal
function automatic mat_t decompose_lu(input mat_t a, output logic sing);
  lu_cplx_pkg::cplx_t rcp;
  lu_cplx_pkg::cplx_t l;
  sing = 1'b0;
  for (int k = 0; k < lu_mem_pkg::mat_n - 1; k++) begin
    rcp = recip_q8(a[k][k]);
    if (a[k][k] == '0) begin
      sing = 1'b1;
    end
    for (int i = k + 1; i < lu_mem_pkg::mat_n; i++) begin
      l = mul_q8(a[i][k], rcp);
      for (int j = k + 1; j < lu_mem_pkg::mat_n; j++) begin
        a[i][j] = sub_wrap(a[i][j], mul_q8(l, a[k][j]));
      end
      a[i][k] = l;
    end
  end
  return a;
endfunction

`endif

// ==== tb_lu_top.sv ====
`default_nettype none

module tb_lu_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int grant_limit = 64; // cycles
  localparam int run_limit   = 4000;

  logic                          clk;
  logic                          rst_n;
  logic                          start;
  logic                          host_req;
  logic                          host_we;
  logic [lu_mem_pkg::addr_w-1:0] host_addr;
  lu_mem_pkg::row_t              host_wdata;
  logic                          host_gnt;
  logic                          host_rvalid;
  lu_mem_pkg::row_t              host_rdata;
  logic                          busy;
  logic                          done;
  logic                          singular;

  integer seed;
  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  int     done_cnt;

  `include "lu_ref_model.svh"

  lu_top u_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .start_i       (start),
    .host_req_i    (host_req),
    .host_we_i     (host_we),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .busy_o        (busy),
    .done_o        (done),
    .singular_o    (singular)
  );

  always #2 clk = ~clk;

  // done pulses counted mid-cycle
  always @(negedge clk) begin
    if (done === 1'b1) begin
      done_cnt++;
    end
  end

  task automatic expect_equal(input logic [127:0] got, input logic [127:0] exp,
                              input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    err_cnt++;
    $display("Timeout: %s did not arrive within the cycle limit at %0t ns", what, $time);
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_before) ? "ok" : "FAILED");
  endtask

  function automatic logic signed [15:0] rand_part(input int lo, input int hi);
    int v;
    v = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    return v[15:0];
  endfunction

  // diagonal parts 2.0 to 4.0 and the rest -0.5 to 0.5
  function automatic mat_t dominant_matrix();
    mat_t m;
    for (int i = 0; i < lu_mem_pkg::mat_n; i++) begin
      for (int j = 0; j < lu_mem_pkg::mat_n; j++) begin
        m[i][j].re = (i == j) ? rand_part(512, 1024) : rand_part(-128, 128);
        m[i][j].im = (i == j) ? rand_part(512, 1024) : rand_part(-128, 128);
      end
    end
    return m;
  endfunction

  task automatic host_access(input logic we, input logic [lu_mem_pkg::addr_w-1:0] addr,
                             input lu_mem_pkg::row_t wdata, output lu_mem_pkg::row_t rdata);
    int   n;
    logic granted;
    n       = 0;
    granted = 1'b0;
    rdata   = '0;
    @(posedge clk);
    #1;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    while (!granted && n < grant_limit) begin
      @(negedge clk);
      granted = host_gnt;
      n++;
    end
    @(posedge clk); // grant edge
    #1;
    host_req = 1'b0;
    if (!granted) begin
      report_timeout("host grant");
    end else if (!we) begin
      @(negedge clk);
      expect_equal(host_rvalid, 1'b1, "host rvalid one cycle after grant");
      rdata = host_rdata;
    end
  endtask

  task automatic load_matrix(input mat_t m);
    lu_mem_pkg::row_t unused;
    for (int r = 0; r < lu_mem_pkg::mat_n; r++) begin
      host_access(1'b1, r[lu_mem_pkg::addr_w-1:0], m[r], unused);
    end
  endtask

  task automatic read_and_compare(input mat_t exp, input string tag);
    lu_mem_pkg::row_t got;
    for (int r = 0; r < lu_mem_pkg::mat_n; r++) begin
      host_access(1'b0, r[lu_mem_pkg::addr_w-1:0], '0, got);
      expect_equal(got, exp[r], $sformatf("%s row %0d", tag, r));
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // returns on the edge that closes the done cycle
  task automatic wait_runs(input int target);
    int n;
    n = 0;
    while (done_cnt < target && n < run_limit) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < target) begin
      report_timeout("done_o");
    end
  endtask

  task automatic decompose_and_check(input mat_t a, input mat_t exp, input logic exp_sing,
                                     input int busy_reads, input string tag);
    int               base;
    int               n;
    integer           pick;
    lu_mem_pkg::row_t rd;
    load_matrix(a);
    base = done_cnt;
    pulse_start();
    @(negedge clk);
    expect_equal(busy, 1'b1, {tag, " busy after start"});
    // reads back to back so some collide with engine requests
    n = 0;
    while (n < busy_reads && busy) begin
      pick = $random(seed);
      host_access(1'b0, pick[lu_mem_pkg::addr_w-1:0], '0, rd);
      n++;
    end
    wait_runs(base + 1);
    @(negedge clk);
    expect_equal(done_cnt, base + 1, {tag, " done pulse count"});
    expect_equal(singular, exp_sing, {tag, " singular"});
    read_and_compare(exp, tag);
  endtask

  initial begin
    mat_t             a;
    mat_t             exp;
    logic             sing;
    lu_mem_pkg::row_t rows [lu_mem_pkg::mat_n];
    lu_mem_pkg::row_t unused;
    int               e0;
    int               base;
    seed       = 35733;
    clk        = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    done_cnt   = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    e0 = err_cnt;
    @(negedge clk);
    expect_equal(busy, 1'b0, "busy after reset");
    expect_equal(done, 1'b0, "done after reset");
    expect_equal(singular, 1'b0, "singular after reset");
    for (int r = 0; r < lu_mem_pkg::mat_n; r++) begin
      for (int j = 0; j < lu_mem_pkg::mat_n; j++) begin
        rows[r][j] = $random(seed);
      end
      host_access(1'b1, r[lu_mem_pkg::addr_w-1:0], rows[r], unused);
    end
    for (int r = 0; r < lu_mem_pkg::mat_n; r++) begin
      host_access(1'b0, r[lu_mem_pkg::addr_w-1:0], '0, unused);
      expect_equal(unused, rows[r], $sformatf("host readback row %0d", r));
    end
    report_test("host write and read", e0);

    e0 = err_cnt;
    for (int t = 0; t < 10; t++) begin
      a   = dominant_matrix();
      exp = decompose_lu(a, sing);
      decompose_and_check(a, exp, 1'b0, 0, $sformatf("random matrix %0d", t));
    end
    report_test("random matrices", e0);

    e0 = err_cnt;
    a = '0;
    for (int i = 0; i < lu_mem_pkg::mat_n; i++) begin
      a[i][i].re = 16'sh0100; // 1.0
    end
    decompose_and_check(a, a, 1'b0, 0, "identity");
    a = dominant_matrix();
    for (int i = 1; i < lu_mem_pkg::mat_n; i++) begin
      for (int j = 0; j < i; j++) begin
        a[i][j] = '0;
      end
    end
    decompose_and_check(a, a, 1'b0, 0, "upper triangular");
    report_test("identity and upper triangular", e0);

    e0 = err_cnt;
    a    = dominant_matrix();
    a[0] = '0;
    exp  = decompose_lu(a, sing);
    decompose_and_check(a, exp, 1'b1, 0, "zero first row");
    report_test("singular pivot", e0);

    e0 = err_cnt;
    a   = dominant_matrix();
    exp = decompose_lu(a, sing);
    decompose_and_check(a, exp, 1'b0, 64, "host reads while busy");
    report_test("host reads while busy", e0);

    e0 = err_cnt;
    a   = dominant_matrix();
    exp = decompose_lu(a, sing);
    exp = decompose_lu(exp, sing); // second run works on the first result
    load_matrix(a);
    base = done_cnt;
    pulse_start();
    repeat (3) begin
      repeat (40) @(posedge clk); // spread across the pivots
      @(negedge clk);
      expect_equal(busy, 1'b1, "busy before extra start");
      pulse_start();
    end
    wait_runs(base + 1);
    #1;
    start = 1'b1; // cycle after done
    @(negedge clk);
    expect_equal(done_cnt, base + 1, "done pulses of first run");
    @(posedge clk);
    #1;
    start = 1'b0;
    wait_runs(base + 2);
    repeat (20) @(negedge clk);
    expect_equal(done_cnt, base + 2, "done pulses of both runs");
    expect_equal(busy, 1'b0, "busy after second run");
    read_and_compare(exp, "back to back");
    report_test("back to back runs", e0);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
lu_cplx_pkg.sv
lu_mem_pkg.sv
row_bus_if.sv
row_mem.sv
row_mem_arbiter.sv
cplx_recip.sv
cplx_mul.sv
lu_engine.sv
lu_top.sv
tb_lu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_lu_top
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f

SOURCES := $(shell grep -v '^+' $(FILELIST)) lu_ref_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when the file list or a source changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
